// ==== common/soc_bus_pkg.sv ====
// APB bus widths and the request and response structs of the peripheral fabric
package soc_bus_pkg;

	localparam int unsigned ADDR_WIDTH = 12;
	localparam int unsigned DATA_WIDTH = 32;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// driven by the master
	// select is not in here, each slot gets its own select bit
	typedef struct packed {
		addr_t paddr;
		logic  pwrite;
		data_t pwdata;
		logic  penable;
	} apb_req_t;

	// returned by the selected slave
	typedef struct packed {
		data_t prdata;
		logic  pready;
	} apb_rsp_t;

	// answer of an unmapped slot
	localparam apb_rsp_t RSP_INVALID = '{prdata: '0, pready: 1'b1};

endpackage

// ==== common/soc_map_pkg.sv ====
// slot map, device ids, register offsets and sizing of the peripheral block
package soc_map_pkg;

	// slot number sits in the address bits above this one
	localparam int unsigned SLOT_SHIFT = 8;
	localparam int unsigned SLOT_COUNT = 16;
	localparam int unsigned SLOT_BITS  = $clog2(SLOT_COUNT);

	typedef logic [SLOT_BITS-1:0]  slot_t;
	typedef logic [SLOT_SHIFT-1:0] ofs_t;

	localparam int unsigned SLOT_DEVTBL     = 0;
	localparam int unsigned SLOT_INTCTRL    = 1;
	localparam int unsigned SLOT_GPIO_FIRST = 2;

	localparam int unsigned GPIO_BANKS = 4;
	localparam int unsigned GPIO_WIDTH = 8;
	// first slot that has no device behind it
	localparam int unsigned SLOT_USED  = SLOT_GPIO_FIRST + GPIO_BANKS;

	localparam int unsigned DEVID_DEVTBL    = 7;
	localparam int unsigned DEVID_INTCTRL   = 3;
	localparam int unsigned DEVID_GPIO      = 6;
	localparam int unsigned DEVID_NONE      = 0;
	localparam int unsigned DEVTBL_INTR_BIT = 31;
	localparam ofs_t        DEVTBL_RST_OFS  = 8'h40;

	localparam ofs_t GPIO_IN_OFS   = 8'h00;
	localparam ofs_t GPIO_OUT_OFS  = 8'h04;
	localparam ofs_t GPIO_MASK_OFS = 8'h08;
	localparam ofs_t GPIO_CHG_OFS  = 8'h0C;

	localparam ofs_t INT_PEND_OFS = 8'h00;
	localparam ofs_t INT_BEST_OFS = 8'h04;
	localparam ofs_t INT_EN_OFS   = 8'h08;
	localparam int unsigned INT_NONE = 32'hFFFF_FFFF;

	localparam int unsigned RST_HOLD_CYCLES = 16;

endpackage

// ==== src/reset_seq.sv ====
// reset sequencer that stretches the peripheral reset after power-on or warm reset
`timescale 1ns/1ns

module reset_seq (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic warm_rst_i,
	output logic soc_rst_o
);
	import soc_map_pkg::*;

	localparam int unsigned CNT_WIDTH = $clog2(RST_HOLD_CYCLES + 1);

	logic [CNT_WIDTH-1:0] hold_cnt_q;

	// reload on either reset source, then count down to zero
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || warm_rst_i) begin
			hold_cnt_q <= CNT_WIDTH'(RST_HOLD_CYCLES);
		end else if (hold_cnt_q != '0) begin
			hold_cnt_q <= hold_cnt_q - 1'b1;
		end
	end

	assign soc_rst_o = rst_p || (hold_cnt_q != '0);

endmodule

// ==== src/apb_decoder.sv ====
// APB address decoder with one-hot slot select and response mux
`timescale 1ns/1ns

module apb_decoder (
	input  soc_bus_pkg::apb_req_t              req_i,
	input  logic                               psel_i,
	output logic [soc_map_pkg::SLOT_COUNT-1:0] slot_sel_o,
	input  soc_bus_pkg::apb_rsp_t              slot_rsp_i [soc_map_pkg::SLOT_COUNT],
	output soc_bus_pkg::apb_rsp_t              rsp_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	slot_t slot;
	logic  slot_mapped;

	assign slot        = req_i.paddr[SLOT_SHIFT +: SLOT_BITS];
	assign slot_mapped = (slot < SLOT_USED);

	// select follows psel into the addressed slot only
	always_comb begin
		slot_sel_o       = '0;
		slot_sel_o[slot] = psel_i;
	end

	// empty slots complete at once and read as zero
	assign rsp_o = slot_mapped ? slot_rsp_i[slot] : RSP_INVALID;

endmodule

// ==== src/devtbl.sv ====
// device table with id and interrupt-use word per slot, plus the warm reset register
`timescale 1ns/1ns

module devtbl (
	input  logic                  clk100mhz_i,
	input  logic                  soc_rst_i,
	input  soc_bus_pkg::apb_req_t req_i,
	input  logic                  sel_i,
	output soc_bus_pkg::apb_rsp_t rsp_o,
	output logic                  warm_rst_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	// id in the low bits, interrupt use in the top bit
	function automatic data_t id_word(input int unsigned slot);
		data_t word;
		if (slot == SLOT_DEVTBL) begin
			word = DATA_WIDTH'(DEVID_DEVTBL);
		end else if (slot == SLOT_INTCTRL) begin
			word = DATA_WIDTH'(DEVID_INTCTRL);
			word[DEVTBL_INTR_BIT] = 1'b1;
		end else if (slot >= SLOT_GPIO_FIRST && slot < SLOT_USED) begin
			word = DATA_WIDTH'(DEVID_GPIO);
			word[DEVTBL_INTR_BIT] = 1'b1;
		end else begin
			word = DATA_WIDTH'(DEVID_NONE);
		end
		return word;
	endfunction

	data_t                 id_table [SLOT_COUNT];
	ofs_t                  ofs;
	logic [SLOT_SHIFT-3:0] word_idx;
	logic                  wr_en;
	logic                  warm_rst_q;

	for (genvar s = 0; s < SLOT_COUNT; s++) begin : g_table
		assign id_table[s] = id_word(s);
	end

	assign ofs      = req_i.paddr[SLOT_SHIFT-1:0];
	assign word_idx = ofs[SLOT_SHIFT-1:2];
	assign wr_en    = sel_i && req_i.penable && req_i.pwrite;

	// table words at slot*4, reset register reads back zero
	always_comb begin
		rsp_o.pready = 1'b1;
		rsp_o.prdata = '0;
		if (ofs[1:0] == 2'b00 && word_idx < SLOT_COUNT) begin
			rsp_o.prdata = id_table[slot_t'(word_idx)];
		end
	end

	// single cycle pulse per accepted write
	always_ff @(posedge clk100mhz_i) begin
		if (soc_rst_i) begin
			warm_rst_q <= 1'b0;
		end else begin
			warm_rst_q <= wr_en && (ofs == DEVTBL_RST_OFS) && req_i.pwdata[0];
		end
	end

	assign warm_rst_o = warm_rst_q;

endmodule

// ==== src/intctrl.sv ====
// interrupt controller that masks the GPIO requests and reports the lowest pending source
`timescale 1ns/1ns

module intctrl (
	input  logic                               clk100mhz_i,
	input  logic                               soc_rst_i,
	input  soc_bus_pkg::apb_req_t              req_i,
	input  logic                               sel_i,
	output soc_bus_pkg::apb_rsp_t              rsp_o,
	input  logic [soc_map_pkg::GPIO_BANKS-1:0] irq_src_i,
	output logic                               irq_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [GPIO_BANKS-1:0] en_q;
	logic [GPIO_BANKS-1:0] pending;
	data_t                 best;
	ofs_t                  ofs;
	logic                  wr_en;
	logic                  irq_q;

	assign ofs     = req_i.paddr[SLOT_SHIFT-1:0];
	assign wr_en   = sel_i && req_i.penable && req_i.pwrite;
	assign pending = irq_src_i & en_q;

	// scan downwards so the lowest pending index is left
	always_comb begin
		best = DATA_WIDTH'(INT_NONE);
		for (int i = GPIO_BANKS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				best = DATA_WIDTH'(i);
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (soc_rst_i) begin
			en_q  <= '0;
			irq_q <= 1'b0;
		end else begin
			if (wr_en && ofs == INT_EN_OFS) begin
				en_q <= req_i.pwdata[GPIO_BANKS-1:0];
			end
			irq_q <= |pending;
		end
	end

	always_comb begin
		rsp_o.pready = 1'b1;
		case (ofs)
			INT_PEND_OFS: rsp_o.prdata = DATA_WIDTH'(pending);
			INT_BEST_OFS: rsp_o.prdata = best;
			INT_EN_OFS:   rsp_o.prdata = DATA_WIDTH'(en_q);
			default:      rsp_o.prdata = '0;
		endcase
	end

	assign irq_o = irq_q;

endmodule

// ==== gpio/gpio_bank.sv ====
// GPIO bank with input synchronizer, output register, change detection and interrupt
`timescale 1ns/1ns

module gpio_bank (
	input  logic                               clk100mhz_i,
	input  logic                               soc_rst_i,
	input  soc_bus_pkg::apb_req_t              req_i,
	input  logic                               sel_i,
	output soc_bus_pkg::apb_rsp_t              rsp_o,
	input  logic [soc_map_pkg::GPIO_WIDTH-1:0] pin_i,
	output logic [soc_map_pkg::GPIO_WIDTH-1:0] pin_o,
	output logic                               irq_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [GPIO_WIDTH-1:0] sync1_q;
	logic [GPIO_WIDTH-1:0] sync2_q;
	logic [GPIO_WIDTH-1:0] prev_q;
	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] mask_q;
	logic [GPIO_WIDTH-1:0] chg_q;
	logic [GPIO_WIDTH-1:0] edge_det;
	logic [GPIO_WIDTH-1:0] chg_clr;
	ofs_t                  ofs;
	logic                  wr_en;
	logic                  irq_q;

	assign ofs      = req_i.paddr[SLOT_SHIFT-1:0];
	assign wr_en    = sel_i && req_i.penable && req_i.pwrite;
	assign edge_det = sync2_q ^ prev_q;
	assign chg_clr  = (wr_en && ofs == GPIO_CHG_OFS) ? req_i.pwdata[GPIO_WIDTH-1:0] : '0;

	// two stage synchronizer, third stage keeps the previous level
	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= pin_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (soc_rst_i) begin
			out_q  <= '0;
			mask_q <= '0;
			chg_q  <= '0;
			irq_q  <= 1'b0;
		end else begin
			if (wr_en && ofs == GPIO_OUT_OFS) begin
				out_q <= req_i.pwdata[GPIO_WIDTH-1:0];
			end
			if (wr_en && ofs == GPIO_MASK_OFS) begin
				mask_q <= req_i.pwdata[GPIO_WIDTH-1:0];
			end
			// a fresh edge wins over a clear in the same cycle
			chg_q <= (chg_q & ~chg_clr) | edge_det;
			irq_q <= |(chg_q & mask_q);
		end
	end

	always_comb begin
		rsp_o.pready = 1'b1;
		case (ofs)
			GPIO_IN_OFS:   rsp_o.prdata = DATA_WIDTH'(sync2_q);
			GPIO_OUT_OFS:  rsp_o.prdata = DATA_WIDTH'(out_q);
			GPIO_MASK_OFS: rsp_o.prdata = DATA_WIDTH'(mask_q);
			GPIO_CHG_OFS:  rsp_o.prdata = DATA_WIDTH'(chg_q);
			default:       rsp_o.prdata = '0;
		endcase
	end

	assign pin_o = out_q;
	assign irq_o = irq_q;

endmodule

// ==== src/periph_soc.sv ====
// peripheral subsystem top with decoder, device table, interrupt controller and GPIO banks
`timescale 1ns/1ns

module periph_soc (
	input  logic                                                       clk100mhz_i,
	input  logic                                                       rst_p,
	input  soc_bus_pkg::apb_req_t                                      req_i,
	input  logic                                                       psel_i,
	output soc_bus_pkg::apb_rsp_t                                      rsp_o,
	input  logic [soc_map_pkg::GPIO_BANKS*soc_map_pkg::GPIO_WIDTH-1:0] gp_i,
	output logic [soc_map_pkg::GPIO_BANKS*soc_map_pkg::GPIO_WIDTH-1:0] gp_o,
	output logic                                                       irq_o,
	output logic                                                       periph_rst_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic                  soc_rst;
	logic                  warm_rst;
	logic [SLOT_COUNT-1:0] slot_sel;
	apb_rsp_t              slot_rsp [SLOT_COUNT];
	logic [GPIO_BANKS-1:0] gpio_irq;

	reset_seq u_reset_seq (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.warm_rst_i  (warm_rst),
		.soc_rst_o   (soc_rst)
	);

	apb_decoder u_decoder (
		.req_i      (req_i),
		.psel_i     (psel_i),
		.slot_sel_o (slot_sel),
		.slot_rsp_i (slot_rsp),
		.rsp_o      (rsp_o)
	);

	devtbl u_devtbl (
		.clk100mhz_i (clk100mhz_i),
		.soc_rst_i   (soc_rst),
		.req_i       (req_i),
		.sel_i       (slot_sel[SLOT_DEVTBL]),
		.rsp_o       (slot_rsp[SLOT_DEVTBL]),
		.warm_rst_o  (warm_rst)
	);

	intctrl u_intctrl (
		.clk100mhz_i (clk100mhz_i),
		.soc_rst_i   (soc_rst),
		.req_i       (req_i),
		.sel_i       (slot_sel[SLOT_INTCTRL]),
		.rsp_o       (slot_rsp[SLOT_INTCTRL]),
		.irq_src_i   (gpio_irq),
		.irq_o       (irq_o)
	);

	// bank g owns slot SLOT_GPIO_FIRST+g and pin slice g
	for (genvar g = 0; g < GPIO_BANKS; g++) begin : g_gpio
		gpio_bank u_gpio (
			.clk100mhz_i (clk100mhz_i),
			.soc_rst_i   (soc_rst),
			.req_i       (req_i),
			.sel_i       (slot_sel[SLOT_GPIO_FIRST+g]),
			.rsp_o       (slot_rsp[SLOT_GPIO_FIRST+g]),
			.pin_i       (gp_i[g*GPIO_WIDTH +: GPIO_WIDTH]),
			.pin_o       (gp_o[g*GPIO_WIDTH +: GPIO_WIDTH]),
			.irq_o       (gpio_irq[g])
		);
	end

	// the decoder answers for these slots itself
	for (genvar u = SLOT_USED; u < SLOT_COUNT; u++) begin : g_empty
		assign slot_rsp[u] = '0;
	end

	assign periph_rst_o = soc_rst;

endmodule

// ==== bench/tb_periph_soc.sv ====
// testbench for the peripheral subsystem that drives APB transfers and GPIO pins
`timescale 1ns/1ns

module tb_periph_soc;
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int CLK_PERIOD  = 10;
	localparam int XFER_CYCLES = 3;
	// rough length of each test in clock cycles
	localparam int T_DEVTBL   = SLOT_COUNT * XFER_CYCLES;
	localparam int T_GPIO     = GPIO_BANKS * (3 * XFER_CYCLES + 4);
	localparam int T_UNMAPPED = (SLOT_COUNT + 4) * XFER_CYCLES;
	localparam int T_IRQ      = (GPIO_BANKS + 6) * XFER_CYCLES + 26;
	localparam int T_PRIO     = (GPIO_BANKS + 12) * XFER_CYCLES + 40;
	localparam int T_WARM     = (2 * GPIO_BANKS + 2) * XFER_CYCLES + RST_HOLD_CYCLES + 8;
	localparam int RUN_CYCLES = 5 + T_DEVTBL + T_GPIO + T_UNMAPPED + T_IRQ + T_PRIO + T_WARM;

	logic                             clk;
	logic                             rst_p;
	apb_req_t                         req;
	logic                             psel;
	apb_rsp_t                         rsp;
	logic [GPIO_BANKS*GPIO_WIDTH-1:0] gp_i;
	logic [GPIO_BANKS*GPIO_WIDTH-1:0] gp_o;
	logic                             irq;
	logic                             periph_rst;

	int    seed;
	int    tests;
	int    checks;
	int    errors;
	int    errs_at_start;
	int    last_waits;
	string test_name;

	periph_soc dut_i (
		.clk100mhz_i  (clk),
		.rst_p        (rst_p),
		.req_i        (req),
		.psel_i       (psel),
		.rsp_o        (rsp),
		.gp_i         (gp_i),
		.gp_o         (gp_o),
		.irq_o        (irq),
		.periph_rst_o (periph_rst)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Checks failed");
		$finish;
	end

	function automatic addr_t reg_addr(input int unsigned slot, input ofs_t ofs);
		return addr_t'(slot << SLOT_SHIFT) | addr_t'(ofs);
	endfunction

	// flag in bit 31, device id below it
	function automatic data_t expected_id(input int unsigned slot);
		if (slot == SLOT_DEVTBL)
			return {1'b0, 31'(DEVID_DEVTBL)};
		if (slot == SLOT_INTCTRL)
			return {1'b1, 31'(DEVID_INTCTRL)};
		if (slot >= SLOT_GPIO_FIRST && slot < SLOT_GPIO_FIRST + GPIO_BANKS)
			return {1'b1, 31'(DEVID_GPIO)};
		return {1'b0, 31'(DEVID_NONE)};
	endfunction

	task automatic check_eq(input string what, input data_t exp, input data_t act);
		checks++;
		assert (act === exp) else begin
			$display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("Test %s failed: %s", test_name, msg);
			errors++;
		end
	endtask

	// setup cycle, then access cycles until pready
	task automatic apb_xfer(input addr_t addr, input bit wr, input data_t wdata,
			output data_t rdata);
		@(posedge clk);
		#1;
		psel = 1'b1;
		req = '{paddr: addr, pwrite: wr, pwdata: wdata, penable: 1'b0};
		@(posedge clk);
		#1;
		req.penable = 1'b1;
		#2;
		last_waits = 0;
		while (!rsp.pready && last_waits < 8) begin
			@(posedge clk);
			#3;
			last_waits++;
		end
		check_true(rsp.pready, $sformatf("no pready for address %h", addr));
		rdata = rsp.prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		req.penable = 1'b0;
	endtask

	task automatic reg_write(input addr_t addr, input data_t data);
		data_t unused;
		apb_xfer(addr, 1'b1, data, unused);
	endtask

	task automatic read_check(input addr_t addr, input data_t exp, input string what);
		data_t rd;
		apb_xfer(addr, 1'b0, '0, rd);
		check_eq(what, exp, rd);
	endtask

	// samples periph_rst_o or irq_o in the middle of each cycle
	task automatic wait_level(input bit on_rst, input logic level, input int bound,
			output bit seen);
		seen = 1'b0;
		for (int n = 0; n < bound && !seen; n++) begin
			@(posedge clk);
			#2;
			seen = ((on_rst ? periph_rst : irq) === level);
		end
	endtask

	task automatic toggle_pin(input int bank, input int pin);
		@(posedge clk);
		#1;
		gp_i[bank*GPIO_WIDTH + pin] = ~gp_i[bank*GPIO_WIDTH + pin];
	endtask

	task automatic clear_changes();
		for (int g = 0; g < GPIO_BANKS; g++)
			reg_write(reg_addr(SLOT_GPIO_FIRST + g, GPIO_CHG_OFS), 32'hFF);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errs_at_start = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s finished with %0d errors", test_name, errors - errs_at_start);
	endtask

	initial begin
		int    k;
		int    b;
		bit    seen;
		data_t val;
		data_t rd;
		logic [GPIO_BANKS*GPIO_WIDTH-1:0] gp_before;

		seed = 32'h231;
		tests = 0;
		checks = 0;
		errors = 0;
		rst_p = 1'b1;
		psel = 1'b0;
		req = '0;
		gp_i = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_p = 1'b0;
		wait_level(1'b1, 1'b0, RST_HOLD_CYCLES + 4, seen);

		start_test("devtbl");
		for (int s = 0; s < SLOT_COUNT; s++)
			read_check(reg_addr(SLOT_DEVTBL, ofs_t'(s * 4)), expected_id(s),
				$sformatf("id word of slot %0d", s));
		end_test();

		start_test("gpio_data");
		for (int g = 0; g < GPIO_BANKS; g++) begin
			val = $random(seed) & 32'hFF;
			reg_write(reg_addr(SLOT_GPIO_FIRST + g, GPIO_OUT_OFS), val);
			check_eq($sformatf("gp_o of bank %0d", g), val,
				32'(gp_o[g*GPIO_WIDTH +: GPIO_WIDTH]));
			read_check(reg_addr(SLOT_GPIO_FIRST + g, GPIO_OUT_OFS), val, "out readback");
			val = $random(seed) & 32'hFF;
			@(posedge clk);
			#1;
			gp_i[g*GPIO_WIDTH +: GPIO_WIDTH] = val[GPIO_WIDTH-1:0];
			// two synchronizer stages before the input register sees it
			repeat (3) @(posedge clk);
			read_check(reg_addr(SLOT_GPIO_FIRST + g, GPIO_IN_OFS), val, "input readback");
		end
		end_test();

		start_test("unmapped");
		for (int s = SLOT_USED; s < SLOT_COUNT; s++) begin
			apb_xfer(reg_addr(s, ofs_t'($random(seed)) & 8'hFC), 1'b0, '0, rd);
			check_eq($sformatf("read of slot %0d", s), '0, rd);
			check_true(last_waits == 0, $sformatf("slot %0d did not answer at once", s));
		end
		gp_before = gp_o;
		reg_write(reg_addr(SLOT_USED, GPIO_OUT_OFS), $random(seed));
		reg_write(reg_addr(SLOT_COUNT - 1, INT_EN_OFS), 32'hF);
		check_eq("gp_o after unmapped writes", gp_before, gp_o);
		read_check(reg_addr(SLOT_INTCTRL, INT_EN_OFS), '0, "enable after unmapped write");
		end_test();

		start_test("irq_single");
		k = int'($unsigned($random(seed)) % GPIO_BANKS);
		b = int'($unsigned($random(seed)) % GPIO_WIDTH);
		clear_changes();
		reg_write(reg_addr(SLOT_GPIO_FIRST + k, GPIO_MASK_OFS), data_t'(1) << b);
		reg_write(reg_addr(SLOT_INTCTRL, INT_EN_OFS), data_t'(1) << k);
		toggle_pin(k, b);
		wait_level(1'b0, 1'b1, 12, seen);
		check_true(seen, "irq_o did not rise after an input change");
		read_check(reg_addr(SLOT_INTCTRL, INT_PEND_OFS), data_t'(1) << k, "pending");
		read_check(reg_addr(SLOT_INTCTRL, INT_BEST_OFS), data_t'(k), "best");
		reg_write(reg_addr(SLOT_GPIO_FIRST + k, GPIO_CHG_OFS), data_t'(1) << b);
		wait_level(1'b0, 1'b0, 12, seen);
		check_true(seen, "irq_o stayed high after the change bit was cleared");
		read_check(reg_addr(SLOT_INTCTRL, INT_BEST_OFS), INT_NONE, "best after clear");
		reg_write(reg_addr(SLOT_GPIO_FIRST + k, GPIO_MASK_OFS), '0);
		end_test();

		start_test("irq_priority");
		clear_changes();
		reg_write(reg_addr(SLOT_GPIO_FIRST + 2, GPIO_MASK_OFS), 32'h1);
		reg_write(reg_addr(SLOT_GPIO_FIRST + 3, GPIO_MASK_OFS), 32'h1);
		reg_write(reg_addr(SLOT_INTCTRL, INT_EN_OFS), 32'hC);
		toggle_pin(2, 0);
		toggle_pin(3, 0);
		wait_level(1'b0, 1'b1, 12, seen);
		check_true(seen, "irq_o did not rise with two banks pending");
		read_check(reg_addr(SLOT_INTCTRL, INT_PEND_OFS), 32'hC, "pending of two banks");
		read_check(reg_addr(SLOT_INTCTRL, INT_BEST_OFS), 32'd2, "best of two banks");
		reg_write(reg_addr(SLOT_GPIO_FIRST + 2, GPIO_CHG_OFS), 32'h1);
		reg_write(reg_addr(SLOT_GPIO_FIRST + 3, GPIO_CHG_OFS), 32'h1);
		wait_level(1'b0, 1'b0, 12, seen);
		check_true(seen, "irq_o stayed high after both change bits were cleared");
		// bank 0 enabled in intctrl but its pin mask stays zero
		reg_write(reg_addr(SLOT_INTCTRL, INT_EN_OFS), 32'h1);
		reg_write(reg_addr(SLOT_GPIO_FIRST, GPIO_MASK_OFS), '0);
		toggle_pin(0, 0);
		wait_level(1'b0, 1'b1, 12, seen);
		check_true(!seen, "irq_o rose for a masked input");
		read_check(reg_addr(SLOT_GPIO_FIRST, GPIO_CHG_OFS), 32'h1, "change of masked pin");
		end_test();

		start_test("warm_reset");
		// nonzero masks in every bank so the reset has something to clear
		for (int g = 0; g < GPIO_BANKS; g++)
			reg_write(reg_addr(SLOT_GPIO_FIRST + g, GPIO_MASK_OFS), 32'hFF);
		reg_write(reg_addr(SLOT_DEVTBL, DEVTBL_RST_OFS), 32'h1);
		wait_level(1'b1, 1'b1, 4, seen);
		check_true(seen, "periph_rst_o did not rise after a warm reset write");
		wait_level(1'b1, 1'b0, RST_HOLD_CYCLES + 4, seen);
		check_true(seen, "periph_rst_o stayed high past the hold time");
		check_eq("gp_o after warm reset", '0, gp_o);
		for (int g = 0; g < GPIO_BANKS; g++)
			read_check(reg_addr(SLOT_GPIO_FIRST + g, GPIO_MASK_OFS), '0, "mask after reset");
		read_check(reg_addr(SLOT_INTCTRL, INT_EN_OFS), '0, "enable after reset");
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== sim.f ====
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
src/reset_seq.sv
src/apb_decoder.sv
src/devtbl.sv
src/intctrl.sv
gpio/gpio_bank.sv
src/periph_soc.sv
bench/tb_periph_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_periph_soc \
	-f sim.f -Mdir obj_dir -o tb_periph_soc
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_periph_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
